//--- Makefile
# Verilator build and run of the muldiv testbench

TOP := muldiv_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- common/muldiv_engine_if.sv
interface muldiv_engine_if;
	import muldiv_pkg::*;

	// issuer side
	// one-cycle pulse, only while busy is low
	logic start;
	// drop the operation in flight
	logic flush;
	// W form, low 32 bits of each operand
	logic word;
	logic a_signed;
	logic b_signed;
	// sampled on the start cycle
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;

	// engine side
	logic busy;
	// one-cycle pulse, result valid only here
	logic done;
	engine_result_u result;

	modport issuer (
		output start, flush, word, a_signed, b_signed, a, b,
		input busy, done, result
	);

	modport engine (
		input start, flush, word, a_signed, b_signed, a, b,
		output busy, done, result
	);

endinterface

//--- common/muldiv_pkg.sv
package muldiv_pkg;

	// ******************************
	// widths
	// ******************************

	// register width of the core
	localparam int xlen = 64;
	// low half used by the W forms
	localparam int word_len = 32;
	// word bit followed by funct3
	localparam int op_width = 4;
	localparam int op_word_bit = 3;

	// booth operands carry two extra sign bits
	localparam int booth_len = xlen + 2;
	// one radix-4 digit per step
	localparam int booth_steps = booth_len / 2;
	// word mode only needs 34 multiplier bits
	localparam int booth_steps_w = (word_len + 2) / 2;

	// step counter, wide enough for the 64 divide steps
	localparam int step_cnt_width = $clog2(xlen + 1);

	// ******************************
	// operation codes
	// ******************************

	// funct3 of the M extension, word bit clear
	localparam logic [op_width-1:0] op_mul = 4'd0;
	localparam logic [op_width-1:0] op_mulh = 4'd1;
	localparam logic [op_width-1:0] op_mulhsu = 4'd2;
	localparam logic [op_width-1:0] op_mulhu = 4'd3;
	localparam logic [op_width-1:0] op_div = 4'd4;
	localparam logic [op_width-1:0] op_divu = 4'd5;
	localparam logic [op_width-1:0] op_rem = 4'd6;
	localparam logic [op_width-1:0] op_remu = 4'd7;

	// ******************************
	// engine result
	// ******************************

	// same 128 bits, read per engine
	typedef union packed {
		// multiplier view
		struct packed {
			logic [xlen-1:0] hi;
			logic [xlen-1:0] lo;
		} product;
		// divider view
		struct packed {
			logic [xlen-1:0] rem;
			logic [xlen-1:0] quot;
		} quotient_pair;
	} engine_result_u;

endpackage

//--- divider/restoring_divider.sv
module restoring_divider (
	input logic clk,
	input logic rst,
	muldiv_engine_if.engine eng
);
	import muldiv_pkg::*;

	// control
	logic busy_q;
	logic done_q;
	logic [step_cnt_width-1:0] count_q;
	// quotient shifts in from the bottom, dividend out the top
	logic [xlen-1:0] quot_q;
	logic [xlen-1:0] rem_q;
	logic [xlen-1:0] divisor_q;
	// result signs
	logic quot_neg_q;
	logic rem_neg_q;
	// operand shaping
	logic [xlen-1:0] a_in;
	logic [xlen-1:0] b_in;
	logic [xlen-1:0] a_abs;
	logic [xlen-1:0] b_abs;
	logic [xlen-1:0] min_val;
	logic neg_a;
	logic neg_b;
	logic div_zero;
	logic overflow;
	// one restoring step
	logic [xlen:0] partial;
	logic [xlen:0] diff;
	engine_result_u res;

	// ******************************
	// operand prep
	// ******************************

	// W form extends the low word by signedness
	assign a_in = eng.word ?
		{{(xlen - word_len){eng.a_signed & eng.a[word_len-1]}}, eng.a[word_len-1:0]} : eng.a;
	assign b_in = eng.word ?
		{{(xlen - word_len){eng.b_signed & eng.b[word_len-1]}}, eng.b[word_len-1:0]} : eng.b;

	assign neg_a = eng.a_signed & a_in[xlen-1];
	assign neg_b = eng.b_signed & b_in[xlen-1];
	// magnitudes, most negative value becomes 2^63 unsigned
	assign a_abs = neg_a ? -a_in : a_in;
	assign b_abs = neg_b ? -b_in : b_in;

	// most negative value of the current width, already extended
	assign min_val = eng.word ?
		{{(xlen - word_len + 1){1'b1}}, {(word_len - 1){1'b0}}} :
		{1'b1, {(xlen - 1){1'b0}}};

	assign div_zero = (b_in == '0);
	assign overflow = eng.a_signed && eng.b_signed && (a_in == min_val) && (b_in == '1);

	// trial subtract
	assign partial = {rem_q, quot_q[xlen-1]};
	assign diff = partial - {1'b0, divisor_q};

	// control FSM
	// special cases skip the steps and only run the finish cycle
	always_ff @(posedge clk) begin
		if (rst || eng.flush) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			count_q <= '0;
		end else if (eng.start) begin
			busy_q <= 1'b1;
			done_q <= 1'b0;
			if (div_zero || overflow)
				count_q <= '0;
			else
				count_q <= eng.word ? step_cnt_width'(word_len) : step_cnt_width'(xlen);
		end else if (done_q) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else if (busy_q) begin
			if (count_q != '0)
				count_q <= count_q - 1'b1;
			else
				done_q <= 1'b1;
		end
	end

	// ******************************
	// datapath
	// ******************************
	always_ff @(posedge clk) begin
		if (eng.start) begin
			divisor_q <= b_abs;
			if (div_zero) begin
				// all ones, remainder is the dividend
				quot_q <= '1;
				rem_q <= a_in;
				quot_neg_q <= 1'b0;
				rem_neg_q <= 1'b0;
			end else if (overflow) begin
				// quotient is the dividend, no remainder
				quot_q <= a_in;
				rem_q <= '0;
				quot_neg_q <= 1'b0;
				rem_neg_q <= 1'b0;
			end else begin
				// W form parks the word in the top half for 32 steps
				quot_q <= eng.word ? a_abs << word_len : a_abs;
				rem_q <= '0;
				quot_neg_q <= neg_a ^ neg_b;
				// remainder takes the dividend sign
				rem_neg_q <= neg_a;
			end
		end else if (busy_q && !done_q) begin
			if (count_q != '0) begin
				if (!diff[xlen])
					rem_q <= diff[xlen-1:0];
				else
					rem_q <= partial[xlen-1:0];
				quot_q <= {quot_q[xlen-2:0], !diff[xlen]};
			end else begin
				// finish cycle, sign fix
				quot_q <= quot_neg_q ? -quot_q : quot_q;
				rem_q <= rem_neg_q ? -rem_q : rem_q;
			end
		end
	end

	always_comb begin
		res.quotient_pair.rem = rem_q;
		res.quotient_pair.quot = quot_q;
	end

	assign eng.busy = busy_q;
	assign eng.done = done_q;
	assign eng.result = res;

	// busy from start until done or flush
	a_busy_hold: assert property (@(posedge clk) disable iff (rst)
		(eng.start || (busy_q && !done_q)) && !eng.flush |=> busy_q);

endmodule

//--- list.f
common/muldiv_pkg.sv
common/muldiv_engine_if.sv
multiplier/booth_multiplier.sv
divider/restoring_divider.sv
source/muldiv_dispatch.sv
source/muldiv_unit.sv
tests/tb_clock.sv
tests/muldiv_tb.sv

//--- multiplier/booth_multiplier.sv
module booth_multiplier (
	input logic clk,
	input logic rst,
	muldiv_engine_if.engine eng
);
	import muldiv_pkg::*;

	// control
	logic busy_q;
	logic done_q;
	logic [step_cnt_width-1:0] count_q;
	// multiplicand, moves two bits left per step
	logic [2*booth_len-1:0] md_q;
	// multiplier with the implicit zero below bit 0
	logic [booth_len:0] mr_q;
	logic [2*booth_len-1:0] acc_q;
	// operand shaping
	logic [xlen-1:0] a_in;
	logic [xlen-1:0] b_in;
	logic [booth_len-1:0] a_ext;
	logic [booth_len-1:0] b_ext;
	// current partial product
	logic [2*booth_len-1:0] pp;
	engine_result_u res;

	// ******************************
	// operand extension
	// ******************************

	// W form works on the low word, sign extended
	assign a_in = eng.word ?
		{{(xlen - word_len){eng.a[word_len-1]}}, eng.a[word_len-1:0]} : eng.a;
	assign b_in = eng.word ?
		{{(xlen - word_len){eng.b[word_len-1]}}, eng.b[word_len-1:0]} : eng.b;

	// two more bits, sign or zero by flag
	assign a_ext = {{2{eng.a_signed & a_in[xlen-1]}}, a_in};
	assign b_ext = {{2{eng.b_signed & b_in[xlen-1]}}, b_in};

	// ******************************
	// radix-4 booth digit
	// ******************************
	always_comb begin
		case (mr_q[2:0])
			// +1
			3'b001, 3'b010: pp = md_q;
			// +2
			3'b011: pp = md_q << 1;
			// -2
			3'b100: pp = -(md_q << 1);
			// -1
			3'b101, 3'b110: pp = -md_q;
			// 000 and 111 add nothing
			default: pp = '0;
		endcase
	end

	// control FSM, busy stays high through the done cycle
	always_ff @(posedge clk) begin
		if (rst || eng.flush) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			count_q <= '0;
		end else if (eng.start) begin
			busy_q <= 1'b1;
			done_q <= 1'b0;
			count_q <= eng.word ? step_cnt_width'(booth_steps_w) :
				step_cnt_width'(booth_steps);
		end else if (done_q) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else if (busy_q) begin
			count_q <= count_q - 1'b1;
			// last digit this cycle
			if (count_q == step_cnt_width'(1))
				done_q <= 1'b1;
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (eng.start) begin
			md_q <= {{booth_len{a_ext[booth_len-1]}}, a_ext};
			mr_q <= {b_ext, 1'b0};
			acc_q <= '0;
		end else if (busy_q && !done_q) begin
			acc_q <= acc_q + pp;
			md_q <= md_q << 2;
			// arithmetic shift keeps the top digit right
			mr_q <= {{2{mr_q[booth_len]}}, mr_q[booth_len:2]};
		end
	end

	// low 128 bits hold the full product
	always_comb begin
		res.product.hi = acc_q[2*xlen-1:xlen];
		res.product.lo = acc_q[xlen-1:0];
	end

	assign eng.busy = busy_q;
	assign eng.done = done_q;
	assign eng.result = res;

	// done only inside a running operation
	a_done_busy: assert property (@(posedge clk) disable iff (rst)
		eng.done |-> eng.busy);

endmodule

//--- source/muldiv_dispatch.sv
module muldiv_dispatch (
	input logic clk,
	input logic rst,
	input logic req_valid,
	output logic req_ready,
	input logic [muldiv_pkg::op_width-1:0] req_op,
	input logic [muldiv_pkg::xlen-1:0] req_a,
	input logic [muldiv_pkg::xlen-1:0] req_b,
	input logic flush,
	output logic resp_valid,
	input logic resp_ready,
	output logic [muldiv_pkg::xlen-1:0] resp_data,
	muldiv_engine_if.issuer mul,
	muldiv_engine_if.issuer div
);
	import muldiv_pkg::*;

	// latched request
	logic [op_width-1:0] op_q;
	logic [xlen-1:0] a_q;
	logic [xlen-1:0] b_q;
	// control
	logic in_flight_q;
	logic issue_q;
	logic resp_valid_q;
	logic [xlen-1:0] resp_data_q;
	logic accept;
	// decode of the latched op
	logic [op_width-1:0] op_base;
	logic a_signed;
	logic b_signed;
	logic use_div;
	logic use_hi;
	logic use_rem;
	// result path
	logic eng_done;
	engine_result_u eng_result;
	logic [xlen-1:0] picked;
	logic [xlen-1:0] shaped;

	// no new request while busy, holding a response or flushing
	assign req_ready = !in_flight_q && !resp_valid_q && !flush;
	assign accept = req_valid && req_ready;

	// ******************************
	// op decode
	// ******************************
	always_comb begin
		op_base = op_q;
		op_base[op_word_bit] = 1'b0;
		a_signed = 1'b0;
		b_signed = 1'b0;
		use_div = 1'b0;
		use_hi = 1'b0;
		use_rem = 1'b0;
		case (op_base)
			// low half is the same for any signedness
			op_mul: use_hi = 1'b0;
			op_mulh: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
				use_hi = 1'b1;
			end
			op_mulhsu: begin
				a_signed = 1'b1;
				use_hi = 1'b1;
			end
			op_mulhu: use_hi = 1'b1;
			op_div: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
				use_div = 1'b1;
			end
			op_divu: use_div = 1'b1;
			op_rem: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
				use_div = 1'b1;
				use_rem = 1'b1;
			end
			op_remu: begin
				use_div = 1'b1;
				use_rem = 1'b1;
			end
			default: use_div = 1'b0;
		endcase
	end

	// both engines see the same operands, only one gets start
	assign mul.start = issue_q && !use_div;
	assign div.start = issue_q && use_div;
	assign mul.flush = flush;
	assign div.flush = flush;
	assign mul.word = op_q[op_word_bit];
	assign div.word = op_q[op_word_bit];
	assign mul.a_signed = a_signed;
	assign div.a_signed = a_signed;
	assign mul.b_signed = b_signed;
	assign div.b_signed = b_signed;
	assign mul.a = a_q;
	assign div.a = a_q;
	assign mul.b = b_q;
	assign div.b = b_q;

	// ******************************
	// result select
	// ******************************
	assign eng_done = in_flight_q && (use_div ? div.done : mul.done);
	assign eng_result = use_div ? div.result : mul.result;
	assign picked = use_div ?
		(use_rem ? eng_result.quotient_pair.rem : eng_result.quotient_pair.quot) :
		(use_hi ? eng_result.product.hi : eng_result.product.lo);
	// W forms return bit 31 extended
	assign shaped = op_q[op_word_bit] ?
		{{(xlen - word_len){picked[word_len-1]}}, picked[word_len-1:0]} : picked;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			in_flight_q <= 1'b0;
			issue_q <= 1'b0;
			resp_valid_q <= 1'b0;
		end else begin
			// start goes out one cycle after acceptance
			issue_q <= accept;
			if (accept)
				in_flight_q <= 1'b1;
			else if (eng_done)
				in_flight_q <= 1'b0;
			if (eng_done)
				resp_valid_q <= 1'b1;
			else if (resp_valid_q && resp_ready)
				resp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= req_op;
			a_q <= req_a;
			b_q <= req_b;
		end
		if (eng_done)
			resp_data_q <= shaped;
	end

	assign resp_valid = resp_valid_q;
	assign resp_data = resp_data_q;

	// start never hits a busy engine
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		!(mul.start && mul.busy) && !(div.start && div.busy));
	// response held under back-pressure
	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp_data));

endmodule

//--- source/muldiv_unit.sv
module muldiv_unit (
	input logic clk,
	input logic rst,
	// request side
	input logic req_valid,
	output logic req_ready,
	input logic [muldiv_pkg::op_width-1:0] req_op,
	input logic [muldiv_pkg::xlen-1:0] req_a,
	input logic [muldiv_pkg::xlen-1:0] req_b,
	// branch flush from the core
	input logic flush,
	// response side
	output logic resp_valid,
	input logic resp_ready,
	output logic [muldiv_pkg::xlen-1:0] resp_data
);

	// ******************************
	// engine buses
	// ******************************
	muldiv_engine_if mul_bus ();
	muldiv_engine_if div_bus ();

	// request decode, start and response hold
	muldiv_dispatch u_dispatch (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_op(req_op),
		.req_a(req_a),
		.req_b(req_b),
		.flush(flush),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp_data(resp_data),
		.mul(mul_bus.issuer),
		.div(div_bus.issuer)
	);

	// MUL family
	booth_multiplier u_booth_multiplier (
		.clk(clk),
		.rst(rst),
		.eng(mul_bus.engine)
	);

	// DIV and REM family
	restoring_divider u_restoring_divider (
		.clk(clk),
		.rst(rst),
		.eng(div_bus.engine)
	);

endmodule

//--- tests/muldiv_tb.sv
module muldiv_tb;
	import muldiv_pkg::*;

	localparam int wait_limit = 5000;
	localparam int rand_per_op = 40;
	localparam int num_ops = 13;
	localparam int num_corners = 8;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	logic [op_width-1:0] req_op;
	logic [xlen-1:0] req_a;
	logic [xlen-1:0] req_b;
	logic flush;
	logic resp_valid;
	logic resp_ready;
	logic [xlen-1:0] resp_data;

	// accepted requests, oldest first
	logic [op_width-1:0] op_fifo [$];
	logic [xlen-1:0] a_fifo [$];
	logic [xlen-1:0] b_fifo [$];
	logic [op_width-1:0] op_list [num_ops];
	logic [xlen-1:0] corner_list [num_corners];
	int error_count;
	int timeout_count;
	int req_count;
	int resp_count;
	// random resp_ready when set
	logic backpressure;

	tb_clock u_tb_clock (
		.clk(clk)
	);

	muldiv_unit u_muldiv_unit (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_op(req_op),
		.req_a(req_a),
		.req_b(req_b),
		.flush(flush),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp_data(resp_data)
	);

	// ******************************
	// expected values
	// ******************************

	// RV64M result for one op
	function automatic logic [xlen-1:0] ref_muldiv(input logic [op_width-1:0] op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [op_width-1:0] base;
		logic [2*xlen-1:0] sa_w;
		logic [2*xlen-1:0] ua_w;
		logic [2*xlen-1:0] sb_w;
		logic [2*xlen-1:0] ub_w;
		logic [2*xlen-1:0] prod;
		logic signed [xlen-1:0] sa;
		logic signed [xlen-1:0] sb;
		logic [word_len-1:0] ua32;
		logic [word_len-1:0] ub32;
		logic signed [word_len-1:0] sa32;
		logic signed [word_len-1:0] sb32;
		logic [word_len-1:0] r32;
		logic [xlen-1:0] r;
		logic ovf;
		base = op;
		base[op_word_bit] = 1'b0;
		r = '0;
		r32 = '0;
		if (op[op_word_bit]) begin
			// W forms only look at the low word
			ua32 = a[word_len-1:0];
			ub32 = b[word_len-1:0];
			sa32 = ua32;
			sb32 = ub32;
			ovf = (ua32 == 32'h8000_0000) && (ub32 == '1);
			case (base)
				op_mul: r32 = ua32 * ub32;
				op_div: begin
					if (ub32 == '0)
						r32 = '1;
					else if (ovf)
						r32 = ua32;
					else
						r32 = sa32 / sb32;
				end
				op_divu: r32 = (ub32 == '0) ? '1 : ua32 / ub32;
				op_rem: begin
					if (ub32 == '0)
						r32 = ua32;
					else if (ovf)
						r32 = '0;
					else
						r32 = sa32 % sb32;
				end
				op_remu: r32 = (ub32 == '0) ? ua32 : ua32 % ub32;
				default: r32 = '0;
			endcase
			r = {{(xlen - word_len){r32[word_len-1]}}, r32};
		end else begin
			sa_w = {{xlen{a[xlen-1]}}, a};
			ua_w = {{xlen{1'b0}}, a};
			sb_w = {{xlen{b[xlen-1]}}, b};
			ub_w = {{xlen{1'b0}}, b};
			sa = a;
			sb = b;
			ovf = (a == {1'b1, {(xlen - 1){1'b0}}}) && (b == '1);
			case (base)
				op_mul: begin
					prod = ua_w * ub_w;
					r = prod[xlen-1:0];
				end
				op_mulh: begin
					prod = sa_w * sb_w;
					r = prod[2*xlen-1:xlen];
				end
				op_mulhsu: begin
					prod = sa_w * ub_w;
					r = prod[2*xlen-1:xlen];
				end
				op_mulhu: begin
					prod = ua_w * ub_w;
					r = prod[2*xlen-1:xlen];
				end
				op_div: begin
					if (b == '0)
						r = '1;
					else if (ovf)
						r = a;
					else
						r = sa / sb;
				end
				op_divu: r = (b == '0) ? '1 : a / b;
				op_rem: begin
					if (b == '0)
						r = a;
					else if (ovf)
						r = '0;
					else
						r = sa % sb;
				end
				op_remu: r = (b == '0) ? a : a % b;
				default: r = '0;
			endcase
		end
		return r;
	endfunction

	function automatic logic [op_width-1:0] word_form(input logic [op_width-1:0] op);
		logic [op_width-1:0] w;
		w = op;
		w[op_word_bit] = 1'b1;
		return w;
	endfunction

	// mix of full width and small magnitudes
	function automatic logic [xlen-1:0] rand_operand();
		logic [xlen-1:0] v;
		int unsigned sel;
		v = {$urandom(), $urandom()};
		sel = $urandom_range(0, 3);
		if (sel == 0)
			v = v >> $urandom_range(8, 60);
		else if (sel == 1)
			v = -(v >> $urandom_range(8, 60));
		return v;
	endfunction

	// ******************************
	// checks and requests
	// ******************************
	task automatic check_value(input string name, input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("ERROR: timed out waiting for %s", what);
		timeout_count++;
	endtask

	// keep clear for a request that will be flushed
	task automatic send_request(input logic [op_width-1:0] op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b, input logic keep);
		int cycles;
		logic accepted;
		@(posedge clk);
		req_valid <= 1'b1;
		req_op <= op;
		req_a <= a;
		req_b <= b;
		cycles = 0;
		accepted = 1'b0;
		while (!accepted && cycles < wait_limit) begin
			@(negedge clk);
			// transfer on the next rising edge
			if (req_ready)
				accepted = 1'b1;
			cycles++;
		end
		if (!accepted)
			report_timeout("req_ready");
		else if (keep) begin
			op_fifo.push_back(op);
			a_fifo.push_back(a);
			b_fifo.push_back(b);
			req_count++;
		end
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (resp_count != req_count && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (resp_count != req_count)
			report_timeout("outstanding responses");
	endtask

	// ******************************
	// response side
	// ******************************
	initial begin
		resp_ready = 1'b1;
		forever begin
			@(posedge clk);
			if (backpressure)
				resp_ready <= ($urandom_range(0, 1) == 1);
			else
				resp_ready <= 1'b1;
		end
	end

	// compare, plus hold check under back-pressure
	initial begin
		logic hold_pending;
		logic [xlen-1:0] hold_data;
		logic [op_width-1:0] exp_op;
		logic [xlen-1:0] exp_a;
		logic [xlen-1:0] exp_b;
		hold_pending = 1'b0;
		hold_data = '0;
		forever begin
			@(negedge clk);
			if (rst)
				hold_pending = 1'b0;
			else begin
				if (hold_pending) begin
					check_value("resp_valid", xlen'(1), xlen'(resp_valid));
					check_value("resp_data", hold_data, resp_data);
				end
				hold_pending = resp_valid && !resp_ready && !flush;
				hold_data = resp_data;
				if (resp_valid && resp_ready) begin
					if (op_fifo.size() == 0) begin
						$display("ERROR: response arrived with no request outstanding");
						error_count++;
					end else begin
						exp_op = op_fifo.pop_front();
						exp_a = a_fifo.pop_front();
						exp_b = b_fifo.pop_front();
						check_value("resp_data", ref_muldiv(exp_op, exp_a, exp_b), resp_data);
					end
					resp_count++;
				end
			end
		end
	end

	// ******************************
	// stimulus
	// ******************************
	initial begin
		void'($urandom(88480));
		rst = 1'b1;
		req_valid = 1'b0;
		req_op = '0;
		req_a = '0;
		req_b = '0;
		flush = 1'b0;
		backpressure = 1'b0;
		error_count = 0;
		timeout_count = 0;
		req_count = 0;
		resp_count = 0;
		for (int i = 0; i < 8; i++)
			op_list[i] = op_width'(i);
		op_list[8] = word_form(op_mul);
		op_list[9] = word_form(op_div);
		op_list[10] = word_form(op_divu);
		op_list[11] = word_form(op_rem);
		op_list[12] = word_form(op_remu);
		// zero, one, all ones, both most negative values, junk above a word -1
		corner_list[0] = 64'h0;
		corner_list[1] = 64'h1;
		corner_list[2] = '1;
		corner_list[3] = 64'h8000_0000_0000_0000;
		corner_list[4] = 64'h7fff_ffff_ffff_ffff;
		corner_list[5] = 64'h0000_0000_8000_0000;
		corner_list[6] = 64'hffff_ffff_8000_0000;
		corner_list[7] = 64'h1234_5678_ffff_ffff;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// idle after reset
		@(negedge clk);
		check_value("resp_valid", xlen'(0), xlen'(resp_valid));
		check_value("req_ready", xlen'(1), xlen'(req_ready));

		// random operands per op
		for (int i = 0; i < num_ops; i++)
			for (int n = 0; n < rand_per_op; n++)
				send_request(op_list[i], rand_operand(), rand_operand(), 1'b1);
		wait_drain();

		// every corner pair on every op
		for (int i = 0; i < num_ops; i++)
			for (int x = 0; x < num_corners; x++)
				for (int y = 0; y < num_corners; y++)
					send_request(op_list[i], corner_list[x], corner_list[y], 1'b1);
		// negative first operand
		for (int n = 0; n < 10; n++)
			send_request(op_mulhsu, rand_operand() | 64'h8000_0000_0000_0000,
				rand_operand(), 1'b1);
		wait_drain();

		// random resp_ready
		backpressure = 1'b1;
		for (int n = 0; n < 120; n++)
			send_request(op_list[$urandom_range(0, num_ops - 1)], rand_operand(),
				rand_operand(), 1'b1);
		wait_drain();
		backpressure = 1'b0;

		// flush some cycles after acceptance, divisor kept nonzero
		for (int n = 0; n < 12; n++) begin
			send_request(op_list[$urandom_range(0, 7)], rand_operand(),
				{$urandom(), $urandom()} | 64'h1, 1'b0);
			repeat ($urandom_range(1, 16)) @(posedge clk);
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
			@(negedge clk);
			check_value("req_ready", xlen'(1), xlen'(req_ready));
			send_request(op_list[$urandom_range(0, num_ops - 1)], rand_operand(),
				rand_operand(), 1'b1);
			wait_drain();
		end

		if (resp_count != req_count) begin
			$display("ERROR: %0d requests but %0d responses", req_count, resp_count);
			error_count++;
		end
		$display("errors %0d, timeouts %0d, requests %0d, responses %0d",
			error_count, timeout_count, req_count, resp_count);
		if (error_count == 0 && timeout_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- tests/tb_clock.sv
module tb_clock (
	output logic clk
);

	// half of the 100 unit period
	localparam int half_period = 50;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

endmodule
